// ==== include/rotCoefs.svh ====
// fixed-point cos and sin of k * 11.25 deg for k = 0 to 4
// included inside the scope of the fine rotation core and the model

// coefficient magnitude width, unsigned
localparam int COEF_BITS = 12;

// coefficient fraction bits, unity is 2048
localparam int COEF_FRAC = 11;

// half an lsb of the scaled product, added before the shift
localparam logic signed [COEF_BITS-1:0] ROUND_BIAS = 12'sd1024;

// cosine by fine step
// 0, 11.25, 22.5, 33.75, 45 deg
localparam logic [COEF_BITS-1:0] COS_TAB [0:4] = '{
   12'd2048,
   12'd2009,
   12'd1892,
   12'd1703,
   12'd1448
};

// sine by fine step, sign applied by the core
localparam logic [COEF_BITS-1:0] SIN_TAB [0:4] = '{
   12'd0,
   12'd400,
   12'd784,
   12'd1138,
   12'd1448
};

// ==== rtl/rotatorPkg.sv ====
// sample and selector definitions for the phase rotation datapath
// import into every module that carries iq samples or the phase selector

package rotatorPkg;

   // ------------------------------------------------------------------------
   // datapath widths
   // ------------------------------------------------------------------------

   // i and q component width, two's complement
   localparam int ROT_BITS = 10;

   // phase selector, 32 steps of 11.25 deg
   localparam int SEL_BITS = 5;

   // in-quadrant fine angle, signed
   // pattern 100 stands for +4, since -4 never occurs
   localparam int FINE_BITS = 3;

   // ------------------------------------------------------------------------
   // sample type
   // ------------------------------------------------------------------------

   // one complex baseband sample, i in the upper half
   typedef struct packed {
      logic signed [ROT_BITS-1:0] i;
      logic signed [ROT_BITS-1:0] q;
   } iqSampleT;

endpackage

// ==== rtl/rotCfgPkg.sv ====
// register map and configuration record of the phase rotation stage
// import where the register block or its decoded fields are used

package rotCfgPkg;

   // bus widths of the strobed write port
   localparam int CFG_ADDR_BITS = 2;
   localparam int CFG_DATA_BITS = 8;

   // phase step and offset field width
   localparam int STEP_BITS = 5;

   // enable position in the control register
   localparam int CTRL_EN_BIT = 0;

   // register addresses
   localparam logic [CFG_ADDR_BITS-1:0] ADDR_STEP0  = 2'd0;
   localparam logic [CFG_ADDR_BITS-1:0] ADDR_STEP1  = 2'd1;
   localparam logic [CFG_ADDR_BITS-1:0] ADDR_OFFSET = 2'd2;
   localparam logic [CFG_ADDR_BITS-1:0] ADDR_CTRL   = 2'd3;

   // decoded configuration, 16 bits
   typedef struct packed {
      logic [STEP_BITS-1:0] step0;
      logic [STEP_BITS-1:0] step1;
      logic [STEP_BITS-1:0] offset;
      logic                 enable;
   } rotCfgT;

endpackage

// ==== rtl/rotCfgRegs.sv ====
// configuration registers of the phase rotation stage
// written by a one-cycle strobe, fields feed the phase accumulator

`timescale 1ns/10ps

module rotCfgRegs
   import rotCfgPkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     cfgWrite,
   input  logic [CFG_ADDR_BITS-1:0] cfgAddr,
   input  logic [CFG_DATA_BITS-1:0] cfgData,
   output rotCfgT                   cfg
);

   // ------------------------------------------------------------------------
   // write decode
   // ------------------------------------------------------------------------

   // the addressed field takes the low data bits on the strobe
   // unused upper data bits are ignored
   always_ff @(posedge clk) begin
      if (reset) begin
         // all steps, offset and enable cleared
         cfg <= '0;
      end else if (cfgWrite) begin
         case (cfgAddr)
            // first modulation index step
            ADDR_STEP0: begin
               cfg.step0 <= cfgData[STEP_BITS-1:0];
            end
            // second modulation index step
            ADDR_STEP1: begin
               cfg.step1 <= cfgData[STEP_BITS-1:0];
            end
            // constant phase offset
            ADDR_OFFSET: begin
               cfg.offset <= cfgData[STEP_BITS-1:0];
            end
            // control, enable only
            ADDR_CTRL: begin
               cfg.enable <= cfgData[CTRL_EN_BIT];
            end
            default: begin
               cfg <= cfg;
            end
         endcase
      end
   end

endmodule

// ==== rtl/phaseAccum.sv ====
// two-index multi-h phase accumulator
// steps the phase on each symbol strobe and adds the offset to form sel

`timescale 1ns/10ps

module phaseAccum
   import rotatorPkg::*;
   import rotCfgPkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  logic                symEn,
   input  rotCfgT              cfg,
   output logic [SEL_BITS-1:0] sel
);

   // accumulated phase, wraps modulo 32
   logic [SEL_BITS-1:0] phase;

   // modulation index, 0 uses step0, 1 uses step1
   logic hIndex;

   always_ff @(posedge clk) begin
      if (reset) begin
         phase  <= '0;
         hIndex <= 1'b0;
      end else if (!cfg.enable) begin
         // held at zero, sel then equals the offset
         phase  <= '0;
         hIndex <= 1'b0;
      end else if (symEn) begin
         // step alternates between the two indices
         phase  <= phase + (hIndex ? cfg.step1 : cfg.step0);
         hIndex <= ~hIndex;
      end
   end

   // from registers only
   // the sample with symEn sees the phase before the update
   assign sel = phase + cfg.offset;

endmodule

// ==== rtl/fineRot.sv ====
// fine rotation core, 0 to 4 steps of 11.25 deg either direction
// two pipeline stages, multiply then sum, round and saturate
// strobes and sel ride along so the caller stays aligned

`timescale 1ns/10ps

module fineRot
   import rotatorPkg::*;
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        symEn,
   input  logic                        sym2xEn,
   input  iqSampleT                    sampleIn,
   input  logic signed [FINE_BITS-1:0] fineAngle,
   input  logic        [SEL_BITS-1:0]  sel,
   output logic                        symEnOut,
   output logic                        sym2xEnOut,
   output logic        [SEL_BITS-1:0]  selOut,
   output iqSampleT                    sampleOut
);

   `include "rotCoefs.svh"

   // ------------------------------------------------------------------------
   // coefficient lookup
   // ------------------------------------------------------------------------

   logic                        fineCw;
   logic        [FINE_BITS-1:0] fineMag;
   logic signed [COEF_BITS:0]   cosC;
   logic signed [COEF_BITS:0]   sinC;

   // negative angles rotate clockwise, 100 is +4
   assign fineCw  = fineAngle[FINE_BITS-1] && (fineAngle[FINE_BITS-2:0] != '0);
   // negation of 100 gives 100, which is magnitude 4 as wanted
   assign fineMag = fineAngle[FINE_BITS-1] ? -fineAngle : fineAngle;

   always_comb begin
      cosC = $signed({1'b0, COS_TAB[fineMag]});
      // clockwise flips the sine only
      if (fineCw) begin
         sinC = -$signed({1'b0, SIN_TAB[fineMag]});
      end else begin
         sinC = $signed({1'b0, SIN_TAB[fineMag]});
      end
   end

   // ------------------------------------------------------------------------
   // stage 1, products
   // ------------------------------------------------------------------------

   logic signed [ROT_BITS+COEF_BITS:0] prodIC, prodQS, prodIS, prodQC;
   logic                               mulSymEn, mulSym2xEn;
   logic [SEL_BITS-1:0]                mulSel;

   always_ff @(posedge clk) begin
      prodIC <= sampleIn.i * cosC;
      prodQS <= sampleIn.q * sinC;
      prodIS <= sampleIn.i * sinC;
      prodQC <= sampleIn.q * cosC;
      mulSel <= sel;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         mulSymEn   <= 1'b0;
         mulSym2xEn <= 1'b0;
      end else begin
         mulSymEn   <= symEn;
         mulSym2xEn <= sym2xEn;
      end
   end

   // ------------------------------------------------------------------------
   // stage 2, sum, round and saturate
   // ------------------------------------------------------------------------

   // one guard bit over the products
   logic signed [ROT_BITS+COEF_BITS+1:0] accI, accQ;

   assign accI = prodIC - prodQS;
   assign accQ = prodIS + prodQC;

   // round half up, shift out the coefficient scale, clamp to sample range
   function automatic logic signed [ROT_BITS-1:0] satRound(
      input logic signed [ROT_BITS+COEF_BITS+1:0] acc
   );
      logic signed [ROT_BITS+COEF_BITS+1:0] scaled;
      scaled = (acc + ROUND_BIAS) >>> COEF_FRAC;
      // upper bits all equal to the sign means it fits
      if ((&scaled[ROT_BITS+COEF_BITS+1:ROT_BITS-1]) ||
          (~|scaled[ROT_BITS+COEF_BITS+1:ROT_BITS-1])) begin
         return scaled[ROT_BITS-1:0];
      end else if (scaled[ROT_BITS+COEF_BITS+1]) begin
         return {1'b1, {(ROT_BITS-1){1'b0}}};
      end else begin
         return {1'b0, {(ROT_BITS-1){1'b1}}};
      end
   endfunction

   always_ff @(posedge clk) begin
      sampleOut.i <= satRound(accI);
      sampleOut.q <= satRound(accQ);
      selOut      <= mulSel;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         symEnOut   <= 1'b0;
         sym2xEnOut <= 1'b0;
      end else begin
         symEnOut   <= mulSymEn;
         sym2xEnOut <= mulSym2xEn;
      end
   end

endmodule

// ==== rtl/rotator.sv ====
// phase rotator by sel * 11.25 deg, fixed latency of 4 cycles
// limit and fold to a quadrant move plus fine angle, fine rotate, re-time
// output strobes mark the cycle in which sampleOut is valid

`timescale 1ns/10ps

module rotator
   import rotatorPkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  logic                symEn,
   input  logic                sym2xEn,
   input  iqSampleT            sampleIn,
   input  logic [SEL_BITS-1:0] sel,
   output logic                symEnOut,
   output logic                sym2xEnOut,
   output iqSampleT            sampleOut
);

   // ------------------------------------------------------------------------
   // limit
   // ------------------------------------------------------------------------

   // most negative value has no positive twin, move it up by one
   function automatic logic signed [ROT_BITS-1:0] limitComp(
      input logic signed [ROT_BITS-1:0] x
   );
      logic signed [ROT_BITS-1:0] minVal;
      minVal = {1'b1, {(ROT_BITS-1){1'b0}}};
      if (x == minVal) begin
         return {1'b1, {(ROT_BITS-2){1'b0}}, 1'b1};
      end else begin
         return x;
      end
   endfunction

   iqSampleT limSample;

   assign limSample.i = limitComp(sampleIn.i);
   assign limSample.q = limitComp(sampleIn.q);

   // ------------------------------------------------------------------------
   // fold
   // ------------------------------------------------------------------------

   logic                        extraTurn;
   logic [1:0]                  coarseTurns;
   logic signed [FINE_BITS-1:0] fineAngle;
   iqSampleT                    coarseSample;

   // in-quadrant angle 5..7 takes one more quarter turn
   assign extraTurn   = sel[FINE_BITS-1] && (sel[FINE_BITS-2:0] != '0);
   assign coarseTurns = sel[SEL_BITS-1:SEL_BITS-2] + extraTurn;

   // low sel bits read as signed already give a - 8 for a above 4
   // and 100 stays +4 in the core
   assign fineAngle = $signed(sel[FINE_BITS-1:0]);

   // quarter turns counterclockwise by swap and negate
   always_comb begin
      case (coarseTurns)
         2'd0: begin
            coarseSample.i = limSample.i;
            coarseSample.q = limSample.q;
         end
         2'd1: begin
            coarseSample.i = -limSample.q;
            coarseSample.q = limSample.i;
         end
         2'd2: begin
            coarseSample.i = -limSample.i;
            coarseSample.q = -limSample.q;
         end
         default: begin
            coarseSample.i = limSample.q;
            coarseSample.q = -limSample.i;
         end
      endcase
   end

   // fold register, cycle 1
   iqSampleT                    foldSample;
   logic signed [FINE_BITS-1:0] foldAngle;
   logic [SEL_BITS-1:0]         foldSel;
   logic                        foldSymEn, foldSym2xEn;

   always_ff @(posedge clk) begin
      foldSample <= coarseSample;
      foldAngle  <= fineAngle;
      foldSel    <= sel;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         foldSymEn   <= 1'b0;
         foldSym2xEn <= 1'b0;
      end else begin
         foldSymEn   <= symEn;
         foldSym2xEn <= sym2xEn;
      end
   end

   // ------------------------------------------------------------------------
   // fine rotation, cycles 2 and 3
   // ------------------------------------------------------------------------

   iqSampleT rotSample;
   logic     rotSymEn, rotSym2xEn;

   // selOut left open, the coarse move is already applied
   fineRot fineRot_i (
      .clk        (clk),
      .reset      (reset),
      .symEn      (foldSymEn),
      .sym2xEn    (foldSym2xEn),
      .sampleIn   (foldSample),
      .fineAngle  (foldAngle),
      .sel        (foldSel),
      .symEnOut   (rotSymEn),
      .sym2xEnOut (rotSym2xEn),
      .selOut     (),
      .sampleOut  (rotSample)
   );

   // ------------------------------------------------------------------------
   // unfold register, cycle 4
   // ------------------------------------------------------------------------

   // re-time only, no second sign decision
   always_ff @(posedge clk) begin
      if (reset) begin
         sampleOut  <= '0;
         symEnOut   <= 1'b0;
         sym2xEnOut <= 1'b0;
      end else begin
         sampleOut  <= rotSample;
         symEnOut   <= rotSymEn;
         sym2xEnOut <= rotSym2xEn;
      end
   end

endmodule

// ==== rtl/rotatorTop.sv ====
// top of the multi-h phase rotation stage
// register block steers the phase accumulator, whose sel drives the rotator

`timescale 1ns/10ps

module rotatorTop
   import rotatorPkg::*;
   import rotCfgPkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     cfgWrite,
   input  logic [CFG_ADDR_BITS-1:0] cfgAddr,
   input  logic [CFG_DATA_BITS-1:0] cfgData,
   input  logic                     symEn,
   input  logic                     sym2xEn,
   input  iqSampleT                 sampleIn,
   output iqSampleT                 sampleOut,
   output logic                     symEnOut,
   output logic                     sym2xEnOut
);

   // decoded configuration
   rotCfgT cfg;

   // phase selector for the current sample
   logic [SEL_BITS-1:0] sel;

   rotCfgRegs rotCfgRegs_i (
      .clk      (clk),
      .reset    (reset),
      .cfgWrite (cfgWrite),
      .cfgAddr  (cfgAddr),
      .cfgData  (cfgData),
      .cfg      (cfg)
   );

   // steps once per symbol
   phaseAccum phaseAccum_i (
      .clk   (clk),
      .reset (reset),
      .symEn (symEn),
      .cfg   (cfg),
      .sel   (sel)
   );

   rotator rotator_i (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .sym2xEn    (sym2xEn),
      .sampleIn   (sampleIn),
      .sel        (sel),
      .symEnOut   (symEnOut),
      .sym2xEnOut (sym2xEnOut),
      .sampleOut  (sampleOut)
   );

endmodule

// ==== sim/rotatorTop_assertions.sv ====
// concurrent checks on the rotation stage, bound into rotatorTop
// strobe latency and the reset state of outputs and configuration

`timescale 1ns/10ps

module rotatorTopAssertions
   import rotatorPkg::*;
   import rotCfgPkg::*;
(
   input logic     clk,
   input logic     reset,
   input logic     symEn,
   input logic     sym2xEn,
   input logic     symEnOut,
   input logic     sym2xEnOut,
   input iqSampleT sampleOut,
   input rotCfgT   cfg
);

   // failed assertions so far, read by the testbench at the end
   int failCount = 0;

   // strobes leave exactly 4 cycles after they enter
   symEnLatency: assert property (@(posedge clk) disable iff (reset)
      symEnOut == $past(symEn, 4))
      else begin
         failCount++;
         $error("symEnOut is not symEn delayed by 4 cycles");
      end

   sym2xEnLatency: assert property (@(posedge clk) disable iff (reset)
      sym2xEnOut == $past(sym2xEn, 4))
      else begin
         failCount++;
         $error("sym2xEnOut is not sym2xEn delayed by 4 cycles");
      end

   // output register cleared by reset
   sampleOutReset: assert property (@(posedge clk) reset |=> sampleOut == '0)
      else begin
         failCount++;
         $error("sampleOut not zero after reset");
      end

   // all fields of the register block cleared
   cfgReset: assert property (@(posedge clk) reset |=> cfg == '0)
      else begin
         failCount++;
         $error("configuration not zero after reset");
      end

endmodule

bind rotatorTop rotatorTopAssertions rotatorTopAssertions_i (
   .clk        (clk),
   .reset      (reset),
   .symEn      (symEn),
   .sym2xEn    (sym2xEn),
   .symEnOut   (symEnOut),
   .sym2xEnOut (sym2xEnOut),
   .sampleOut  (sampleOut),
   .cfg        (cfg)
);

// ==== sim/rotatorTb.sv ====
// testbench for the multi-h phase rotation stage
// LCG stimulus on the falling edge, queue model with the 4-cycle latency
// every output cycle is compared bit-exactly, counts reported at the end

`timescale 1ns/10ps

module rotatorTb
   import rotatorPkg::*;
   import rotCfgPkg::*;
();

   `include "rotCoefs.svh"

   // rotator latency in cycles
   localparam int PIPE_DEPTH = 4;
   // cycle limit of every wait loop
   localparam int WAIT_LIMIT = 20;
   // most negative component and its limited value
   localparam logic signed [ROT_BITS-1:0] NEG_FULL  = {1'b1, {(ROT_BITS-1){1'b0}}};
   localparam logic signed [ROT_BITS-1:0] NEG_LIMIT = NEG_FULL + 1;

   logic                     clk;
   logic                     reset;
   logic                     cfgWrite;
   logic [CFG_ADDR_BITS-1:0] cfgAddr;
   logic [CFG_DATA_BITS-1:0] cfgData;
   logic                     symEn;
   logic                     sym2xEn;
   iqSampleT                 sampleIn;
   iqSampleT                 sampleOut;
   logic                     symEnOut;
   logic                     sym2xEnOut;

   // expected output of one cycle, live marks a real test sample
   typedef struct packed {
      iqSampleT sample;
      logic     symEn;
      logic     sym2xEn;
      logic     live;
   } expT;

   expT expQ[$];

   // model of the register block and the phase trellis
   logic [SEL_BITS-1:0] mStep0, mStep1, mOffset, mPhase;
   logic                mEnable, mIndex;

   // register write for the next driven cycle
   logic                     pendWrite;
   logic [CFG_ADDR_BITS-1:0] pendAddr;
   logic [CFG_DATA_BITS-1:0] pendData;

   logic [31:0] lcgState;
   int          checks, errors, testErrStart, symOutSeen;

   rotatorTop rotatorTop_i (
      .clk        (clk),
      .reset      (reset),
      .cfgWrite   (cfgWrite),
      .cfgAddr    (cfgAddr),
      .cfgData    (cfgData),
      .symEn      (symEn),
      .sym2xEn    (sym2xEn),
      .sampleIn   (sampleIn),
      .sampleOut  (sampleOut),
      .symEnOut   (symEnOut),
      .sym2xEnOut (sym2xEnOut)
   );

   // 100 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   // ------------------------------------------------------------------------
   // random numbers and model
   // ------------------------------------------------------------------------

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // upper LCG bits, the low ones repeat quickly
   function automatic iqSampleT randSample();
      logic [31:0] r;
      iqSampleT    s;
      r = nextRand();
      s.i = r[31:22];
      s.q = r[21:12];
      return s;
   endfunction

   function automatic logic signed [ROT_BITS-1:0] clipMin(input logic signed [ROT_BITS-1:0] x);
      if (x == NEG_FULL) begin
         return NEG_LIMIT;
      end
      return x;
   endfunction

   function automatic logic signed [ROT_BITS-1:0] clampComp(input int x);
      int hi;
      int lo;
      hi = (1 << (ROT_BITS-1)) - 1;
      lo = -(1 << (ROT_BITS-1));
      if (x > hi) begin
         return hi[ROT_BITS-1:0];
      end else if (x < lo) begin
         return lo[ROT_BITS-1:0];
      end
      return x[ROT_BITS-1:0];
   endfunction

   // rotation by selV * 11.25 deg after the limit rule
   function automatic iqSampleT modelRotate(input iqSampleT s, input logic [SEL_BITS-1:0] selV);
      int       xi, xq, t, quads, a, fine, mag, c, sn, ri, rq;
      iqSampleT r;
      xi = clipMin(s.i);
      xq = clipMin(s.q);
      quads = selV[4:3];
      a = selV[2:0];
      // past 45 deg, one more quarter turn then back clockwise
      if (a > 4) begin
         quads = quads + 1;
         fine = a - 8;
      end else begin
         fine = a;
      end
      repeat (quads % 4) begin
         t = xi;
         xi = -xq;
         xq = t;
      end
      mag = (fine < 0) ? -fine : fine;
      c = COS_TAB[mag];
      sn = SIN_TAB[mag];
      if (fine < 0) begin
         sn = -sn;
      end
      ri = (xi * c - xq * sn + (1 << (COEF_FRAC-1))) >>> COEF_FRAC;
      rq = (xi * sn + xq * c + (1 << (COEF_FRAC-1))) >>> COEF_FRAC;
      r.i = clampComp(ri);
      r.q = clampComp(rq);
      return r;
   endfunction

   // ------------------------------------------------------------------------
   // drive, check and report
   // ------------------------------------------------------------------------

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("Fail %s: expected 0x%08h, got 0x%08h", name, expected, actual);
      end
   endtask

   // one clock, outputs checked before the new inputs go out
   task automatic tick(input iqSampleT s, input logic se, input logic s2, input logic live);
      expT                 e;
      logic [SEL_BITS-1:0] selM;
      @(negedge clk);
      if (expQ.size() >= PIPE_DEPTH) begin
         e = expQ.pop_front();
         checkValue("sampleOut.i", e.sample.i, sampleOut.i);
         checkValue("sampleOut.q", e.sample.q, sampleOut.q);
         checkValue("symEnOut", e.symEn, symEnOut);
         checkValue("sym2xEnOut", e.sym2xEn, sym2xEnOut);
         // symbol strobes seen on the DUT output for test samples
         if (e.live && symEnOut) begin
            symOutSeen++;
         end
      end
      sampleIn = s;
      symEn = se;
      sym2xEn = s2;
      cfgWrite = pendWrite;
      cfgAddr = pendAddr;
      cfgData = pendData;
      // sample sees the phase before this symbol's step
      selM = mPhase + mOffset;
      e.sample = modelRotate(s, selM);
      e.symEn = se;
      e.sym2xEn = s2;
      e.live = live;
      expQ.push_back(e);
      // state after the coming rising edge
      if (!mEnable) begin
         mPhase = '0;
         mIndex = 1'b0;
      end else if (se) begin
         mPhase = mPhase + (mIndex ? mStep1 : mStep0);
         mIndex = ~mIndex;
      end
      if (pendWrite) begin
         case (pendAddr)
            ADDR_STEP0: mStep0 = pendData[SEL_BITS-1:0];
            ADDR_STEP1: mStep1 = pendData[SEL_BITS-1:0];
            ADDR_OFFSET: mOffset = pendData[SEL_BITS-1:0];
            default: mEnable = pendData[0];
         endcase
      end
      pendWrite = 1'b0;
   endtask

   task automatic writeReg(input logic [CFG_ADDR_BITS-1:0] addr,
                           input logic [CFG_DATA_BITS-1:0] data);
      pendWrite = 1'b1;
      pendAddr = addr;
      pendData = data;
      tick('0, 1'b0, 1'b0, 1'b0);
   endtask

   function automatic int pendingLive();
      int cnt;
      cnt = 0;
      foreach (expQ[k]) begin
         if (expQ[k].live) begin
            cnt++;
         end
      end
      return cnt;
   endfunction

   // idle until every test sample has been checked
   task automatic flushPipe();
      int n;
      n = 0;
      while (pendingLive() > 0 && n < WAIT_LIMIT) begin
         tick('0, 1'b0, 1'b0, 1'b0);
         n++;
      end
      if (pendingLive() > 0) begin
         errors++;
         $display("timeout: test samples never left the pipeline");
      end
   endtask

   // reset high over the first 5 rising edges
   task automatic applyReset();
      reset = 1'b1;
      sampleIn = '0;
      symEn = 1'b0;
      sym2xEn = 1'b0;
      cfgWrite = 1'b0;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      {mStep0, mStep1, mOffset, mPhase} = '0;
      mEnable = 1'b0;
      mIndex = 1'b0;
      expQ.delete();
   endtask

   task automatic reportTest(input string name);
      $display("%s done, %0d errors", name, errors - testErrStart);
   endtask

   // ------------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------------

   task automatic resetState();
      iqSampleT s;
      int       n;
      testErrStart = errors;
      checkValue("sampleOut", 32'd0, sampleOut);
      checkValue("symEnOut", 32'd0, symEnOut);
      checkValue("sym2xEnOut", 32'd0, sym2xEnOut);
      // offset 0 and enable off pass the sample straight through
      s = randSample();
      s.i = NEG_FULL;
      tick(s, 1'b1, 1'b0, 1'b1);
      n = 0;
      while (!symEnOut && n < WAIT_LIMIT) begin
         tick('0, 1'b0, 1'b0, 1'b0);
         n++;
      end
      if (!symEnOut) begin
         errors++;
         $display("timeout: symEnOut never rose after the first sample");
      end else begin
         checkValue("latency", PIPE_DEPTH, n);
         checkValue("sampleOut.i", clipMin(s.i), sampleOut.i);
         checkValue("sampleOut.q", clipMin(s.q), sampleOut.q);
      end
      flushPipe();
      reportTest("reset state");
   endtask

   task automatic staticOffsets();
      logic [31:0] r;
      testErrStart = errors;
      for (int off = 0; off < 32; off++) begin
         writeReg(ADDR_OFFSET, off[CFG_DATA_BITS-1:0]);
         repeat (8) begin
            r = nextRand();
            tick(randSample(), r[31], r[30], 1'b1);
         end
      end
      flushPipe();
      reportTest("static offsets");
   endtask

   task automatic limitCase();
      logic [31:0] r;
      iqSampleT    a, b, outA;
      testErrStart = errors;
      for (int k = 0; k < 12; k++) begin
         r = nextRand();
         writeReg(ADDR_OFFSET, {3'b000, r[4:0]});
         a = randSample();
         b = a;
         // i, q, then both at the negative end
         if (k % 3 != 1) begin
            a.i = NEG_FULL;
            b.i = NEG_LIMIT;
         end
         if (k % 3 != 0) begin
            a.q = NEG_FULL;
            b.q = NEG_LIMIT;
         end
         tick(a, 1'b0, 1'b0, 1'b1);
         tick(b, 1'b0, 1'b0, 1'b1);
         repeat (PIPE_DEPTH - 1) tick('0, 1'b0, 1'b0, 1'b0);
         outA = sampleOut;
         tick('0, 1'b0, 1'b0, 1'b0);
         checkValue("sampleOut at limit", outA, sampleOut);
      end
      flushPipe();
      reportTest("limit");
   endtask

   task automatic multiHSteps();
      logic [31:0] r;
      testErrStart = errors;
      for (int k = 0; k < 4; k++) begin
         r = nextRand();
         writeReg(ADDR_STEP0, {3'b000, r[28:24]});
         writeReg(ADDR_STEP1, {3'b000, r[23:19]});
         writeReg(ADDR_OFFSET, {3'b000, r[18:14]});
         writeReg(ADDR_CTRL, 8'h01);
         repeat (40) begin
            r = nextRand();
            tick(randSample(), r[31], r[30], 1'b1);
         end
         writeReg(ADDR_CTRL, 8'h00);
         flushPipe();
      end
      reportTest("multi-h stepping");
   endtask

   task automatic randomTraffic();
      logic [31:0] r;
      int          sent, outStart;
      testErrStart = errors;
      r = nextRand();
      writeReg(ADDR_STEP0, {3'b000, r[31:27]});
      writeReg(ADDR_STEP1, {3'b000, r[26:22]});
      writeReg(ADDR_CTRL, 8'h01);
      outStart = symOutSeen;
      sent = 0;
      // a sample every cycle, symEn only with sym2xEn
      repeat (100) begin
         r = nextRand();
         tick(randSample(), r[31], r[31] | r[30], 1'b1);
         sent += r[31];
      end
      writeReg(ADDR_CTRL, 8'h00);
      flushPipe();
      checkValue("symEnOut pulses", sent, symOutSeen - outStart);
      reportTest("strobe alignment");
   endtask

   initial begin
      lcgState = 32'h86a4_11f4;
      reset = 1'b1;
      cfgWrite = 1'b0;
      cfgAddr = '0;
      cfgData = '0;
      symEn = 1'b0;
      sym2xEn = 1'b0;
      sampleIn = '0;
      pendWrite = 1'b0;
      pendAddr = '0;
      pendData = '0;
      checks = 0;
      errors = 0;
      symOutSeen = 0;
      applyReset();
      resetState();
      staticOffsets();
      limitCase();
      multiHSteps();
      randomTraffic();
      errors += rotatorTop_i.rotatorTopAssertions_i.failCount;
      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
               rotatorTop_i.rotatorTopAssertions_i.failCount);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+include
rtl/rotatorPkg.sv
rtl/rotCfgPkg.sv
rtl/rotCfgRegs.sv
rtl/phaseAccum.sv
rtl/fineRot.sv
rtl/rotator.sv
rtl/rotatorTop.sv
sim/rotatorTop_assertions.sv
sim/rotatorTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile the rotator testbench with Verilator, run it, and judge the run from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rotatorTb -f list.f -o simv \
   > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1 \
   || echo "simulator exited with an error"

grep -qx "Test OK" sim.log && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
